/* Makefile */
# Verilator build and run for the bypass unit testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f bypassUnit.f --top-module bypassUnitTb

# the log decides the result, the simulator exit status alone does not.
run: compile
	./obj_dir/VbypassUnitTb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bypassUnit.f */
+incdir+include
source/bypassPkg.sv
source/bypassSelIf.sv
source/bypassSelectGen.sv
source/bypassNetwork.sv
source/bypassUnit.sv
verif/bypassUnitTb.sv

/* include/bypassNet_cfg.svh */
//##################################################
// bypass unit configuration
// lane counts and operand widths of the back end.
//##################################################

`ifndef BYPASS_NET_CFG_SVH
`define BYPASS_NET_CFG_SVH

// integer issue lanes, each one producer and one consumer.
`define BYPASS_INT_WIDTH 2

// load lanes, each one producer and one consumer.
`define BYPASS_MEM_WIDTH 1

`define BYPASS_TAG_BITS  6 // physical register number.
`define BYPASS_DATA_BITS 32

`endif

/* source/bypassNetwork.sv */
//##################################################
// bypass network
// holds in-flight results and muxes each operand
// from them or from the register file.
//##################################################

`default_nettype none
`timescale 1ns/100ps

`include "bypassNet_cfg.svh"

module bypassNetwork
    import bypassPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        clear,
    input  logic        intDstValid [`BYPASS_INT_WIDTH],
    input  PRegData     intDstData  [`BYPASS_INT_WIDTH],
    input  logic        memDstValid [`BYPASS_MEM_WIDTH],
    input  PRegData     memDstData  [`BYPASS_MEM_WIDTH],
    input  PRegData     intRegDataA [`BYPASS_INT_WIDTH],
    input  PRegData     intRegDataB [`BYPASS_INT_WIDTH],
    input  PRegData     memRegDataA [`BYPASS_MEM_WIDTH],
    input  PRegData     memRegDataB [`BYPASS_MEM_WIDTH],
    bypassSelIf.network sel,
    output PRegData     intOperandA [`BYPASS_INT_WIDTH],
    output PRegData     intOperandB [`BYPASS_INT_WIDTH],
    output PRegData     memOperandA [`BYPASS_MEM_WIDTH],
    output PRegData     memOperandB [`BYPASS_MEM_WIDTH]
);

    BypassOperand intEx [`BYPASS_INT_WIDTH];
    BypassOperand intWb [`BYPASS_INT_WIDTH];
    BypassOperand memMa [`BYPASS_MEM_WIDTH];
    BypassOperand memWb [`BYPASS_MEM_WIDTH];
    logic         anyValid;
    logic         selLive;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            // clear drops the valid bits and keeps the data.
            for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
                intEx[i].valid <= 1'b0;
                intWb[i].valid <= 1'b0;
            end
            for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
                memMa[i].valid <= 1'b0;
                memWb[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
                intEx[i] <= '{valid: intDstValid[i], data: intDstData[i]};
                intWb[i] <= intEx[i];
            end
            for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
                memMa[i] <= '{valid: memDstValid[i], data: memDstData[i]};
                memWb[i] <= memMa[i];
            end
        end
    end

    function automatic PRegData selectData(input BypassSelect s, input PRegData regData);
        case (s.stg)
            BYPASS_STAGE_INT_EX: return intEx[s.lane.intLane].data;
            BYPASS_STAGE_INT_WB: return intWb[s.lane.intLane].data;
            BYPASS_STAGE_MEM_MA: return memMa[s.lane.memLane].data;
            BYPASS_STAGE_MEM_WB: return memWb[s.lane.memLane].data;
            default:             return regData; // no hit selects the register file.
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            intOperandA[i] = selectData(sel.intSelA[i], intRegDataA[i]);
            intOperandB[i] = selectData(sel.intSelB[i], intRegDataB[i]);
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            memOperandA[i] = selectData(sel.memSelA[i], memRegDataA[i]);
            memOperandB[i] = selectData(sel.memSelB[i], memRegDataB[i]);
        end
    end

    function automatic logic pointsAtLive(input BypassSelect s);
        case (s.stg)
            BYPASS_STAGE_NONE:   return 1'b1;
            BYPASS_STAGE_INT_EX: return intEx[s.lane.intLane].valid;
            BYPASS_STAGE_INT_WB: return intWb[s.lane.intLane].valid;
            BYPASS_STAGE_MEM_MA: return memMa[s.lane.memLane].valid;
            BYPASS_STAGE_MEM_WB: return memWb[s.lane.memLane].valid;
            default:             return 1'b0;
        endcase
    endfunction

    always_comb begin
        selLive = 1'b1;
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            selLive = selLive && pointsAtLive(sel.intSelA[i])
                && pointsAtLive(sel.intSelB[i]);
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            selLive = selLive && pointsAtLive(sel.memSelA[i])
                && pointsAtLive(sel.memSelB[i]);
        end
    end

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            anyValid = anyValid || intEx[i].valid || intWb[i].valid;
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            anyValid = anyValid || memMa[i].valid || memWb[i].valid;
        end
    end

    // the tag side keeps its own valid bits, which must agree with these.
    selPointsAtLiveData: assert property (@(posedge clk) disable iff (reset) selLive);

    clearEmptiesAll: assert property (@(posedge clk) (reset || clear) |=> !anyValid);

    for (genvar i = 0; i < `BYPASS_INT_WIDTH; i++) begin : gIntHold
        intStallHolds: assert property (@(posedge clk) disable iff (reset)
            (stall && !clear) |=> ($stable(intEx[i]) && $stable(intWb[i])));
    end

    for (genvar i = 0; i < `BYPASS_MEM_WIDTH; i++) begin : gMemHold
        memStallHolds: assert property (@(posedge clk) disable iff (reset)
            (stall && !clear) |=> ($stable(memMa[i]) && $stable(memWb[i])));
    end

endmodule

`default_nettype wire

/* source/bypassPkg.sv */
//##################################################
// bypass types
// tags, data, stage selects and the lane union.
//##################################################

`default_nettype none

`include "bypassNet_cfg.svh"

package bypassPkg;

    // one lane index bit is enough for both lane groups.
    localparam int BYPASS_LANE_BITS =
        (`BYPASS_INT_WIDTH > 1) ? $clog2(`BYPASS_INT_WIDTH) : 1;

    typedef logic [`BYPASS_TAG_BITS-1:0]  PRegTag;
    typedef logic [`BYPASS_DATA_BITS-1:0] PRegData;

    typedef struct packed {
        logic    valid;
        PRegData data;
    } BypassOperand;

    typedef enum logic [2:0] {
        BYPASS_STAGE_NONE   = 3'd0,
        BYPASS_STAGE_INT_EX = 3'd1,
        BYPASS_STAGE_INT_WB = 3'd2,
        BYPASS_STAGE_MEM_MA = 3'd3,
        BYPASS_STAGE_MEM_WB = 3'd4
    } BypassStg;

    // the stage field tells which member is meant.
    typedef union packed {
        logic [BYPASS_LANE_BITS-1:0] intLane;
        logic [BYPASS_LANE_BITS-1:0] memLane;
    } BypassLane;

    typedef struct packed {
        BypassStg  stg;
        BypassLane lane;
    } BypassSelect;

endpackage

`default_nettype wire

/* source/bypassSelIf.sv */
//##################################################
// bypass select bus
// operand selects from the tag compare logic to
// the value multiplexers.
//##################################################

`default_nettype none
`timescale 1ns/100ps

`include "bypassNet_cfg.svh"

interface bypassSelIf import bypassPkg::*; ();

    BypassSelect intSelA [`BYPASS_INT_WIDTH];
    BypassSelect intSelB [`BYPASS_INT_WIDTH];
    BypassSelect memSelA [`BYPASS_MEM_WIDTH];
    BypassSelect memSelB [`BYPASS_MEM_WIDTH];

    modport generator (
        output intSelA, intSelB, memSelA, memSelB
    );

    modport network (
        input intSelA, intSelB, memSelA, memSelB
    );

endinterface

`default_nettype wire

/* source/bypassSelectGen.sv */
//##################################################
// bypass select generator
// tracks in-flight destination tags and picks the
// newest matching position for every operand.
//##################################################

`default_nettype none
`timescale 1ns/100ps

`include "bypassNet_cfg.svh"

module bypassSelectGen
    import bypassPkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          clear,
    input  logic          intDstValid [`BYPASS_INT_WIDTH],
    input  PRegTag        intDstTag   [`BYPASS_INT_WIDTH],
    input  logic          memDstValid [`BYPASS_MEM_WIDTH],
    input  PRegTag        memDstTag   [`BYPASS_MEM_WIDTH],
    input  PRegTag        intSrcTagA  [`BYPASS_INT_WIDTH],
    input  PRegTag        intSrcTagB  [`BYPASS_INT_WIDTH],
    input  PRegTag        memSrcTagA  [`BYPASS_MEM_WIDTH],
    input  PRegTag        memSrcTagB  [`BYPASS_MEM_WIDTH],
    bypassSelIf.generator sel
);

    logic   intExValid [`BYPASS_INT_WIDTH];
    PRegTag intExTag   [`BYPASS_INT_WIDTH];
    logic   intWbValid [`BYPASS_INT_WIDTH];
    PRegTag intWbTag   [`BYPASS_INT_WIDTH];
    logic   memMaValid [`BYPASS_MEM_WIDTH];
    PRegTag memMaTag   [`BYPASS_MEM_WIDTH];
    logic   memWbValid [`BYPASS_MEM_WIDTH];
    PRegTag memWbTag   [`BYPASS_MEM_WIDTH];

    always_ff @(posedge clk) begin
        if (reset || clear) begin // clear wins over stall.
            for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
                intExValid[i] <= 1'b0;
                intWbValid[i] <= 1'b0;
            end
            for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
                memMaValid[i] <= 1'b0;
                memWbValid[i] <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
                intExValid[i] <= intDstValid[i];
                intWbValid[i] <= intExValid[i];
            end
            for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
                memMaValid[i] <= memDstValid[i];
                memWbValid[i] <= memMaValid[i];
            end
        end
    end

    // tags advance whenever the positions do.
    always_ff @(posedge clk) begin
        if (!stall) begin
            intExTag <= intDstTag;
            intWbTag <= intExTag;
            memMaTag <= memDstTag;
            memWbTag <= memMaTag;
        end
    end

    // the newest matching position wins.
    function automatic BypassSelect findSource(input PRegTag srcTag);
        BypassSelect s;
        logic        found;
        s.stg  = BYPASS_STAGE_NONE;
        s.lane = '0;
        found  = 1'b0;
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            if (!found && intExValid[i] && intExTag[i] == srcTag) begin
                s.stg          = BYPASS_STAGE_INT_EX;
                s.lane.intLane = BYPASS_LANE_BITS'(i);
                found          = 1'b1;
            end
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            if (!found && memMaValid[i] && memMaTag[i] == srcTag) begin
                s.stg          = BYPASS_STAGE_MEM_MA;
                s.lane.memLane = BYPASS_LANE_BITS'(i);
                found          = 1'b1;
            end
        end
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            if (!found && intWbValid[i] && intWbTag[i] == srcTag) begin
                s.stg          = BYPASS_STAGE_INT_WB;
                s.lane.intLane = BYPASS_LANE_BITS'(i);
                found          = 1'b1;
            end
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            if (!found && memWbValid[i] && memWbTag[i] == srcTag) begin
                s.stg          = BYPASS_STAGE_MEM_WB;
                s.lane.memLane = BYPASS_LANE_BITS'(i);
                found          = 1'b1;
            end
        end
        return s;
    endfunction

    always_comb begin
        for (int i = 0; i < `BYPASS_INT_WIDTH; i++) begin
            sel.intSelA[i] = findSource(intSrcTagA[i]);
            sel.intSelB[i] = findSource(intSrcTagB[i]);
        end
        for (int i = 0; i < `BYPASS_MEM_WIDTH; i++) begin
            sel.memSelA[i] = findSource(memSrcTagA[i]);
            sel.memSelB[i] = findSource(memSrcTagB[i]);
        end
    end

endmodule

`default_nettype wire

/* source/bypassUnit.sv */
//##################################################
// bypass unit
// joins the select generator and the data network
// behind plain lane ports.
//##################################################

`default_nettype none
`timescale 1ns/100ps

`include "bypassNet_cfg.svh"

module bypassUnit
    import bypassPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    clear,
    input  logic    intDstValid [`BYPASS_INT_WIDTH],
    input  PRegTag  intDstTag   [`BYPASS_INT_WIDTH],
    input  PRegData intDstData  [`BYPASS_INT_WIDTH],
    input  logic    memDstValid [`BYPASS_MEM_WIDTH],
    input  PRegTag  memDstTag   [`BYPASS_MEM_WIDTH],
    input  PRegData memDstData  [`BYPASS_MEM_WIDTH],
    input  PRegTag  intSrcTagA  [`BYPASS_INT_WIDTH],
    input  PRegTag  intSrcTagB  [`BYPASS_INT_WIDTH],
    input  PRegData intRegDataA [`BYPASS_INT_WIDTH],
    input  PRegData intRegDataB [`BYPASS_INT_WIDTH],
    input  PRegTag  memSrcTagA  [`BYPASS_MEM_WIDTH],
    input  PRegTag  memSrcTagB  [`BYPASS_MEM_WIDTH],
    input  PRegData memRegDataA [`BYPASS_MEM_WIDTH],
    input  PRegData memRegDataB [`BYPASS_MEM_WIDTH],
    output PRegData intOperandA [`BYPASS_INT_WIDTH],
    output PRegData intOperandB [`BYPASS_INT_WIDTH],
    output PRegData memOperandA [`BYPASS_MEM_WIDTH],
    output PRegData memOperandB [`BYPASS_MEM_WIDTH]
);

    bypassSelIf selBus ();

    // tag side, decides where each operand comes from.
    bypassSelectGen selectGen_i (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .clear       (clear),
        .intDstValid (intDstValid),
        .intDstTag   (intDstTag),
        .memDstValid (memDstValid),
        .memDstTag   (memDstTag),
        .intSrcTagA  (intSrcTagA),
        .intSrcTagB  (intSrcTagB),
        .memSrcTagA  (memSrcTagA),
        .memSrcTagB  (memSrcTagB),
        .sel         (selBus.generator)
    );

    bypassNetwork network_i (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .clear       (clear),
        .intDstValid (intDstValid),
        .intDstData  (intDstData),
        .memDstValid (memDstValid),
        .memDstData  (memDstData),
        .intRegDataA (intRegDataA),
        .intRegDataB (intRegDataB),
        .memRegDataA (memRegDataA),
        .memRegDataB (memRegDataB),
        .sel         (selBus.network),
        .intOperandA (intOperandA),
        .intOperandB (intOperandB),
        .memOperandA (memOperandA),
        .memOperandB (memOperandB)
    );

endmodule

`default_nettype wire

/* verif/bypassUnitTb.sv */
//##################################################
// bypass unit testbench
// directed and LFSR driven producer traffic, checked
// against a shadow model of the in-flight results.
//##################################################

`default_nettype none
`timescale 1ns/100ps

`include "bypassNet_cfg.svh"

module bypassUnitTb import bypassPkg::*; ();

    localparam int NI = `BYPASS_INT_WIDTH;
    localparam int NM = `BYPASS_MEM_WIDTH;
    localparam int NL = NI + NM;

    logic    clk = 1'b0;
    logic    reset, stall, clear;
    logic    intDstValid [NI];
    PRegTag  intDstTag   [NI];
    PRegData intDstData  [NI];
    logic    memDstValid [NM];
    PRegTag  memDstTag   [NM];
    PRegData memDstData  [NM];
    PRegTag  intSrcTagA  [NI];
    PRegTag  intSrcTagB  [NI];
    PRegData intRegDataA [NI];
    PRegData intRegDataB [NI];
    PRegTag  memSrcTagA  [NM];
    PRegTag  memSrcTagB  [NM];
    PRegData memRegDataA [NM];
    PRegData memRegDataB [NM];
    PRegData intOperandA [NI];
    PRegData intOperandB [NI];
    PRegData memOperandA [NM];
    PRegData memOperandB [NM];

    // shadow positions in priority order, the newer group first and int lanes before mem.
    logic    shValid [2*NL];
    PRegTag  shTag   [2*NL];
    PRegData shData  [2*NL];

    logic [15:0] lfsr = 16'd18858;
    int          checkCount = 0;
    int          errorCount = 0;
    int          stimCycle = 0;
    int          checkedCycle = 0;

    bypassUnit bypassUnit_i (.*);

    always #10 clk = ~clk;

    function automatic logic lfsrStep();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11.
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrStep()};
        end
        return v;
    endfunction

    // eight registers only, so that tags collide often.
    function automatic PRegTag randTag();
        return PRegTag'(32'd8 + randBits(3));
    endfunction

    function automatic PRegData expectedOperand(input PRegTag srcTag, input PRegData regData);
        for (int p = 0; p < 2*NL; p++) begin
            if (shValid[p] && shTag[p] == srcTag) return shData[p];
        end
        return regData;
    endfunction

    task automatic checkValue(input string name, input PRegData expected, input PRegData actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s expected 0x%08h actual 0x%08h at %0t", name, expected, actual,
                $time);
        end
    endtask

    task automatic driveCycle(input logic [NI-1:0] intValid, input logic [NM-1:0] memValid,
                              input logic st, input logic cl, input logic randTags,
                              input PRegTag fixTag);
        @(posedge clk);
        stall <= st;
        clear <= cl;
        for (int i = 0; i < NI; i++) begin
            intDstValid[i] <= intValid[i];
            intDstTag[i]   <= randTags ? randTag() : fixTag;
            intDstData[i]  <= randBits(32);
            intSrcTagA[i]  <= randTags ? randTag() : fixTag;
            intSrcTagB[i]  <= randTags ? randTag() : fixTag;
            intRegDataA[i] <= randBits(32);
            intRegDataB[i] <= randBits(32);
        end
        for (int i = 0; i < NM; i++) begin
            memDstValid[i] <= memValid[i];
            memDstTag[i]   <= randTags ? randTag() : fixTag;
            memDstData[i]  <= randBits(32);
            memSrcTagA[i]  <= randTags ? randTag() : fixTag;
            memSrcTagB[i]  <= randTags ? randTag() : fixTag;
            memRegDataA[i] <= randBits(32);
            memRegDataB[i] <= randBits(32);
        end
        stimCycle++;
    endtask

    task automatic quietCycles(input int n, input PRegTag tag);
        repeat (n) driveCycle('0, '0, 1'b0, 1'b0, 1'b0, tag);
    endtask

    always @(posedge clk) begin
        if (reset || clear) begin
            for (int p = 0; p < 2*NL; p++) shValid[p] <= 1'b0;
        end else if (!stall) begin
            for (int p = 0; p < NL; p++) begin
                shValid[NL+p] <= shValid[p];
                shTag[NL+p]   <= shTag[p];
                shData[NL+p]  <= shData[p];
            end
            for (int i = 0; i < NI; i++) begin
                shValid[i] <= intDstValid[i];
                shTag[i]   <= intDstTag[i];
                shData[i]  <= intDstData[i];
            end
            for (int i = 0; i < NM; i++) begin
                shValid[NI+i] <= memDstValid[i];
                shTag[NI+i]   <= memDstTag[i];
                shData[NI+i]  <= memDstData[i];
            end
        end
    end

    always begin
        @(posedge clk);
        #5; // outputs have settled from the new inputs and positions.
        if (!reset) begin
            for (int i = 0; i < NI; i++) begin
                checkValue($sformatf("intOperandA[%0d]", i),
                    expectedOperand(intSrcTagA[i], intRegDataA[i]), intOperandA[i]);
                checkValue($sformatf("intOperandB[%0d]", i),
                    expectedOperand(intSrcTagB[i], intRegDataB[i]), intOperandB[i]);
            end
            for (int i = 0; i < NM; i++) begin
                checkValue($sformatf("memOperandA[%0d]", i),
                    expectedOperand(memSrcTagA[i], memRegDataA[i]), memOperandA[i]);
                checkValue($sformatf("memOperandB[%0d]", i),
                    expectedOperand(memSrcTagB[i], memRegDataB[i]), memOperandB[i]);
            end
        end
        checkedCycle = stimCycle;
    end

    initial begin : watchdog
        for (int c = 0; c < 20000; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not reach its end in time.");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int guard;
        reset <= 1'b1;
        stall <= 1'b0;
        clear <= 1'b0;
        for (int i = 0; i < NI; i++) begin
            intDstValid[i] <= 1'b0;
            intDstTag[i]   <= '0;
            intDstData[i]  <= '0;
            intSrcTagA[i]  <= '0;
            intSrcTagB[i]  <= '0;
            intRegDataA[i] <= '0;
            intRegDataB[i] <= '0;
        end
        for (int i = 0; i < NM; i++) begin
            memDstValid[i] <= 1'b0;
            memDstTag[i]   <= '0;
            memDstData[i]  <= '0;
            memSrcTagA[i]  <= '0;
            memSrcTagB[i]  <= '0;
            memRegDataA[i] <= '0;
            memRegDataB[i] <= '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        quietCycles(4, 6'd5);
        // one producer at a time, then three cycles to drain.
        driveCycle(2'b01, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5);
        quietCycles(3, 6'd5);
        driveCycle(2'b10, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5);
        quietCycles(3, 6'd5);
        driveCycle(2'b00, 1'b1, 1'b0, 1'b0, 1'b0, 6'd5);
        quietCycles(3, 6'd5);
        // same tag everywhere, newest first must win.
        driveCycle(2'b11, 1'b1, 1'b0, 1'b0, 1'b0, 6'd9);
        driveCycle(2'b00, 1'b1, 1'b0, 1'b0, 1'b0, 6'd9);
        quietCycles(3, 6'd9);
        driveCycle(2'b01, 1'b0, 1'b0, 1'b0, 1'b0, 6'd12);
        repeat (3) driveCycle('0, '0, 1'b1, 1'b0, 1'b0, 6'd12);
        quietCycles(3, 6'd12);
        // clear during a stall.
        driveCycle(2'b11, 1'b1, 1'b0, 1'b0, 1'b0, 6'd14);
        driveCycle('0, '0, 1'b1, 1'b0, 1'b0, 6'd14);
        driveCycle('0, '0, 1'b1, 1'b1, 1'b0, 6'd14);
        driveCycle('0, '0, 1'b1, 1'b0, 1'b0, 6'd14);
        quietCycles(2, 6'd14);
        repeat (2000) begin
            driveCycle(NI'(randBits(NI)), NM'(randBits(NM)), randBits(3) == 32'd0,
                randBits(8) < 32'd13, 1'b1, '0);
        end
        guard = 0;
        while (checkedCycle != stimCycle && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        if (checkedCycle != stimCycle) begin
            $display("Timeout: the compare process fell behind the stimulus.");
            errorCount++;
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
